/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// Word and block geometry
	localparam int WORD_BITS = 16;
	localparam int BLOCK_WORDS = 4;
	localparam int OFFSET_BITS = 2; // Word offset inside a block

	// Defaults for the module parameters
	localparam int DEFAULT_MEM_WORDS = 256;
	localparam int DEFAULT_STALL_CYCLES = 4;
	localparam int DEFAULT_LINES = 8;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [WORD_BITS-1:0] addr_t; // Word address

	// Word 0 sits in the low bits
	typedef word_t [BLOCK_WORDS-1:0] block_t;

	// Cache to memory, held until ready or ack
	typedef struct packed {
		logic read;
		logic write;
		addr_t addr; // Block aligned
		block_t wdata;
	} mem_req_t;

	// Memory to cache, one-cycle pulses
	typedef struct packed {
		logic ready; // Read data valid
		logic ack; // Write done
		block_t rdata;
	} mem_rsp_t;

	// Cache controller state, shared by both caches
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		WRITE
	} cache_state_e;

endpackage

`default_nettype wire

/* memory/block_memory.sv */
`default_nettype none

module block_memory #(
	parameter int mem_words = mem_pkg::DEFAULT_MEM_WORDS,
	parameter int stall_cycles = mem_pkg::DEFAULT_STALL_CYCLES
) (
	input logic clk,
	input logic reset_n,
	input mem_pkg::mem_req_t req1,
	output mem_pkg::mem_rsp_t rsp1,
	input mem_pkg::mem_req_t req2,
	output mem_pkg::mem_rsp_t rsp2
);

	localparam int addr_bits = $clog2(mem_words);
	localparam int count_bits = $clog2(stall_cycles);
	localparam int ports = 2;

	mem_pkg::word_t words [mem_words];

	// Per-port request view and state, index 0 is port 1
	mem_pkg::mem_req_t req_a [ports];
	mem_pkg::mem_rsp_t rsp_q [ports];
	logic [count_bits-1:0] count_q [ports];
	mem_pkg::addr_t addr_q [ports];

	assign req_a[0] = req1;
	assign req_a[1] = req2;
	assign rsp1 = rsp_q[0];
	assign rsp2 = rsp_q[1];

	// Array index of word w in the block at base
	function automatic logic [addr_bits-1:0] word_index(mem_pkg::addr_t base, int w);
		return {base[addr_bits-1:mem_pkg::OFFSET_BITS], w[mem_pkg::OFFSET_BITS-1:0]};
	endfunction

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < mem_words; i++) begin
				words[i] <= '0; // Memory comes up zeroed
			end
			for (int p = 0; p < ports; p++) begin
				count_q[p] <= '0;
				addr_q[p] <= '0;
				rsp_q[p] <= '0;
			end
		end else begin
			for (int p = 0; p < ports; p++) begin
				rsp_q[p].ready <= 1'b0;
				rsp_q[p].ack <= 1'b0;
				// The pulse cycle still sees the request, so it must not restart
				if ((req_a[p].read || req_a[p].write) && !rsp_q[p].ready && !rsp_q[p].ack) begin
					if (count_q[p] == '0) begin
						addr_q[p] <= req_a[p].addr; // First request cycle
					end
					if (count_q[p] == count_bits'(stall_cycles - 1)) begin
						count_q[p] <= '0;
						if (req_a[p].read) begin
							rsp_q[p].ready <= 1'b1;
							for (int w = 0; w < mem_pkg::BLOCK_WORDS; w++) begin
								rsp_q[p].rdata[w] <= words[word_index(addr_q[p], w)];
							end
						end else begin
							rsp_q[p].ack <= 1'b1; // Write lands with the ack
							for (int w = 0; w < mem_pkg::BLOCK_WORDS; w++) begin
								words[word_index(addr_q[p], w)] <= req_a[p].wdata[w];
							end
						end
					end else begin
						count_q[p] <= count_q[p] + 1'b1;
					end
				end
			end
		end
	end

	// Data port is either a read or a write, never both
	a_req2_one_op: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(req2.read && req2.write)
	) else $error("port 2 read and write at once");

	// Instruction port only reads
	a_req1_no_write: assert property (
		@(posedge clk) disable iff (!reset_n)
		!req1.write
	) else $error("write request on port 1");

	for (genvar p = 0; p < ports; p++) begin : g_addr_check
		// Requester must hold the block address until the pulse
		a_addr_held: assert property (
			@(posedge clk) disable iff (!reset_n)
			(count_q[p] != '0) && (req_a[p].read || req_a[p].write)
				|-> req_a[p].addr == addr_q[p]
		) else $error("block address changed during request on port %0d", p + 1);
	end

endmodule

`default_nettype wire

/* cache/icache.sv */
`default_nettype none

module icache #(
	parameter int lines = mem_pkg::DEFAULT_LINES
) (
	input logic clk,
	input logic reset_n,
	input logic i_read,
	input mem_pkg::addr_t i_addr,
	output mem_pkg::word_t i_data,
	output logic i_ready,
	output mem_pkg::mem_req_t mem_req,
	input mem_pkg::mem_rsp_t mem_rsp
);

	localparam int index_bits = $clog2(lines);
	localparam int tag_bits = mem_pkg::WORD_BITS - mem_pkg::OFFSET_BITS - index_bits;

	mem_pkg::cache_state_e state;

	// Line storage
	logic [lines-1:0] valid_q;
	logic [tag_bits-1:0] tag_q [lines];
	mem_pkg::block_t data_q [lines];

	// Address split
	logic [mem_pkg::OFFSET_BITS-1:0] offset;
	logic [index_bits-1:0] index;
	logic [tag_bits-1:0] tag;
	logic hit;

	assign offset = i_addr[mem_pkg::OFFSET_BITS-1:0];
	assign index = i_addr[mem_pkg::OFFSET_BITS +: index_bits];
	assign tag = i_addr[mem_pkg::WORD_BITS-1 -: tag_bits];
	assign hit = valid_q[index] && (tag_q[index] == tag);

	// Block read held for the whole fill
	always_comb begin
		mem_req = '0;
		mem_req.read = (state == mem_pkg::FILL);
		mem_req.addr = i_addr & ~mem_pkg::addr_t'(mem_pkg::BLOCK_WORDS - 1);
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= mem_pkg::IDLE;
			valid_q <= '0;
			i_ready <= 1'b0;
		end else begin
			i_ready <= 1'b0; // One-cycle pulse
			case (state)
				mem_pkg::IDLE: begin
					if (i_read && !i_ready) begin
						if (hit) begin
							i_data <= data_q[index][offset];
							i_ready <= 1'b1;
						end else begin
							state <= mem_pkg::FILL;
						end
					end
				end
				mem_pkg::FILL: begin
					if (mem_rsp.ready) begin
						valid_q[index] <= 1'b1;
						tag_q[index] <= tag;
						data_q[index] <= mem_rsp.rdata;
						i_data <= mem_rsp.rdata[offset]; // Answer straight from the fill
						i_ready <= 1'b1;
						state <= mem_pkg::IDLE;
					end
				end
				default: state <= mem_pkg::IDLE; // Read-only, no write state
			endcase
		end
	end

	// Fetch address must not move before the answer
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!reset_n)
		i_read && !i_ready |=> !i_read || i_ready || $stable(i_addr)
	) else $error("i_addr changed while fetch pending");

endmodule

`default_nettype wire

/* cache/dcache.sv */
`default_nettype none

module dcache #(
	parameter int lines = mem_pkg::DEFAULT_LINES
) (
	input logic clk,
	input logic reset_n,
	input logic d_read,
	input logic d_write,
	input mem_pkg::addr_t d_addr,
	input mem_pkg::word_t d_wdata,
	output mem_pkg::word_t d_rdata,
	output logic d_ready,
	output mem_pkg::mem_req_t mem_req,
	input mem_pkg::mem_rsp_t mem_rsp
);

	localparam int index_bits = $clog2(lines);
	localparam int tag_bits = mem_pkg::WORD_BITS - mem_pkg::OFFSET_BITS - index_bits;

	mem_pkg::cache_state_e state;

	// Line storage
	logic [lines-1:0] valid_q;
	logic [tag_bits-1:0] tag_q [lines];
	mem_pkg::block_t data_q [lines];

	// Address split
	logic [mem_pkg::OFFSET_BITS-1:0] offset;
	logic [index_bits-1:0] index;
	logic [tag_bits-1:0] tag;
	logic hit;
	logic access;

	assign offset = d_addr[mem_pkg::OFFSET_BITS-1:0];
	assign index = d_addr[mem_pkg::OFFSET_BITS +: index_bits];
	assign tag = d_addr[mem_pkg::WORD_BITS-1 -: tag_bits];
	assign hit = valid_q[index] && (tag_q[index] == tag);
	assign access = (d_read || d_write) && !d_ready; // Ready cycle closes an access

	// Fill reads the block, WRITE pushes the merged line through
	always_comb begin
		mem_req = '0;
		mem_req.read = (state == mem_pkg::FILL);
		mem_req.write = (state == mem_pkg::WRITE);
		mem_req.addr = d_addr & ~mem_pkg::addr_t'(mem_pkg::BLOCK_WORDS - 1);
		mem_req.wdata = data_q[index];
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= mem_pkg::IDLE;
			valid_q <= '0;
			d_ready <= 1'b0;
		end else begin
			d_ready <= 1'b0; // One-cycle pulse
			case (state)
				mem_pkg::IDLE: begin
					if (access) begin
						if (!hit) begin
							state <= mem_pkg::FILL; // Write-allocate as well
						end else if (d_write) begin
							data_q[index][offset] <= d_wdata; // Merge, neighbours kept
							state <= mem_pkg::WRITE;
						end else begin
							d_rdata <= data_q[index][offset];
							d_ready <= 1'b1;
						end
					end
				end
				mem_pkg::FILL: begin
					if (mem_rsp.ready) begin
						valid_q[index] <= 1'b1;
						tag_q[index] <= tag;
						data_q[index] <= mem_rsp.rdata;
						if (d_read) begin
							d_rdata <= mem_rsp.rdata[offset];
							d_ready <= 1'b1;
						end
						// A pending write now hits and merges from IDLE
						state <= mem_pkg::IDLE;
					end
				end
				mem_pkg::WRITE: begin
					if (mem_rsp.ack) begin
						d_ready <= 1'b1; // Done once memory holds the line
						state <= mem_pkg::IDLE;
					end
				end
				default: state <= mem_pkg::IDLE;
			endcase
		end
	end

	a_one_op: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(d_read && d_write)
	) else $error("d_read and d_write both high");

endmodule

`default_nettype wire

/* rtl/mem_subsystem.sv */
`default_nettype none

module mem_subsystem #(
	parameter int mem_words = mem_pkg::DEFAULT_MEM_WORDS,
	parameter int stall_cycles = mem_pkg::DEFAULT_STALL_CYCLES,
	parameter int lines = mem_pkg::DEFAULT_LINES
) (
	input logic clk,
	input logic reset_n,
	// Instruction side
	input logic i_read,
	input mem_pkg::addr_t i_addr,
	output mem_pkg::word_t i_data,
	output logic i_ready,
	// Data side
	input logic d_read,
	input logic d_write,
	input mem_pkg::addr_t d_addr,
	input mem_pkg::word_t d_wdata,
	output mem_pkg::word_t d_rdata,
	output logic d_ready
);

	mem_pkg::mem_req_t req1; // Instruction cache port
	mem_pkg::mem_rsp_t rsp1;
	mem_pkg::mem_req_t req2; // Data cache port
	mem_pkg::mem_rsp_t rsp2;

	icache #(
		.lines(lines)
	) u_icache (
		.clk(clk),
		.reset_n(reset_n),
		.i_read(i_read),
		.i_addr(i_addr),
		.i_data(i_data),
		.i_ready(i_ready),
		.mem_req(req1),
		.mem_rsp(rsp1)
	);

	dcache #(
		.lines(lines)
	) u_dcache (
		.clk(clk),
		.reset_n(reset_n),
		.d_read(d_read),
		.d_write(d_write),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_rdata(d_rdata),
		.d_ready(d_ready),
		.mem_req(req2),
		.mem_rsp(rsp2)
	);

	block_memory #(
		.mem_words(mem_words),
		.stall_cycles(stall_cycles)
	) u_memory (
		.clk(clk),
		.reset_n(reset_n),
		.req1(req1),
		.rsp1(rsp1),
		.req2(req2),
		.rsp2(rsp2)
	);

endmodule

`default_nettype wire

/* testbench/tb_mem_subsystem.sv */
`default_nettype none

module tb_mem_subsystem;

	localparam int timeout_cycles = 200;

	logic clk;
	logic reset_n;
	logic i_read;
	mem_pkg::addr_t i_addr;
	mem_pkg::word_t i_data;
	logic i_ready;
	logic d_read;
	logic d_write;
	mem_pkg::addr_t d_addr;
	mem_pkg::word_t d_wdata;
	mem_pkg::word_t d_rdata;
	logic d_ready;

	int error_count;
	int timeout_count;
	int op_count;

	mem_subsystem dut (
		.clk(clk),
		.reset_n(reset_n),
		.i_read(i_read),
		.i_addr(i_addr),
		.i_data(i_data),
		.i_ready(i_ready),
		.d_read(d_read),
		.d_write(d_write),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_rdata(d_rdata),
		.d_ready(d_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Holds a data request until d_ready, then leaves one idle cycle
	task automatic data_access(input logic write, input mem_pkg::addr_t addr,
		input mem_pkg::word_t wdata, input string name, output mem_pkg::word_t rdata,
		output logic done);
		int cycles;
		d_read = !write;
		d_write = write;
		d_addr = addr;
		d_wdata = wdata;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
			done = d_ready; // Registered output settles before the falling edge
		end
		rdata = d_rdata;
		d_read = 1'b0;
		d_write = 1'b0;
		if (!done) begin
			$display("Data access %s never completed within %0d cycles", name, timeout_cycles);
			timeout_count++;
		end
		@(negedge clk);
	endtask

	// Holds an instruction fetch until i_ready
	task automatic fetch_word(input mem_pkg::addr_t addr, input string name,
		output mem_pkg::word_t data, output logic done);
		int cycles;
		i_read = 1'b1;
		i_addr = addr;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
			done = i_ready;
		end
		data = i_data;
		i_read = 1'b0;
		if (!done) begin
			$display("Fetch %s never completed within %0d cycles", name, timeout_cycles);
			timeout_count++;
		end
		@(negedge clk);
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		string op;
		string name;
		mem_pkg::addr_t addr;
		mem_pkg::word_t wdata;
		mem_pkg::word_t expected;
		mem_pkg::word_t result;
		logic done;

		error_count = 0;
		timeout_count = 0;
		op_count = 0;
		reset_n = 1'b0;
		i_read = 1'b0;
		i_addr = '0;
		d_read = 1'b0;
		d_write = 1'b0;
		d_addr = '0;
		d_wdata = '0;

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);

		fd = $fopen("testbench/mem_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden data file");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) == 0) break;
				if (line.len() < 2 || line[0] == "#") continue; // Blank or column notes
				fields = $sscanf(line, "%s %h %h %h %s", op, addr, wdata, expected, name);
				if (fields != 5) begin
					$display("Golden line could not be parsed: %s", line);
					error_count++;
					continue;
				end
				op_count++;
				if (op == "W") begin
					data_access(1'b1, addr, wdata, name, result, done);
				end else if (op == "R") begin
					data_access(1'b0, addr, wdata, name, result, done);
					if (done) check_value(name, expected, result);
				end else if (op == "I") begin
					fetch_word(addr, name, result, done);
					if (done) check_value(name, expected, result);
				end else begin
					$display("Unknown operation %s in golden line %s", op, name);
					error_count++;
				end
			end
			$fclose(fd);
			if (op_count == 0) begin
				$display("The golden data file held no operations");
				error_count++;
			end
		end

		$display("%0d operations, %0d errors, %0d timeouts", op_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/mem_golden.txt */
# op addr wdata expect name; op is W data write, R data read, I instruction fetch
# addr, wdata and expect are hex; expect is checked for R and I only
R 0000 0000 0000 reset_read_0
R 0045 0000 0000 reset_read_45
I 0000 0000 0000 reset_fetch_0
I 0081 0000 0000 reset_fetch_81
W 0010 1234 0000 wr_10
R 0010 0000 1234 rd_10
W 0024 beef 0000 wr_24
R 0024 0000 beef rd_24
W 0031 a1a1 0000 merge_wr_31
W 0033 c3c3 0000 merge_wr_33
R 0031 0000 a1a1 merge_rd_31
R 0033 0000 c3c3 merge_rd_33
R 0030 0000 0000 merge_rd_30
R 0032 0000 0000 merge_rd_32
W 0048 1111 0000 conflict_wr_48
W 0068 2222 0000 conflict_wr_68
R 0048 0000 1111 conflict_rd_48
R 0068 0000 2222 conflict_rd_68
W 0089 3333 0000 conflict_wr_89
R 0048 0000 1111 conflict_rd_48_again
R 0089 0000 3333 conflict_rd_89
R 0069 0000 0000 conflict_rd_69
W 004a 4444 0000 conflict_wr_4a
R 0048 0000 1111 conflict_rd_48_merged
R 004a 0000 4444 conflict_rd_4a
R 0068 0000 2222 conflict_rd_68_again
I 0010 0000 1234 fetch_after_wr_10
I 0024 0000 beef fetch_after_wr_24
I 0033 0000 c3c3 fetch_after_wr_33
I 0089 0000 3333 fetch_after_wr_89
I 004a 0000 4444 fetch_after_wr_4a
I 0048 0000 1111 fetch_hit_48

/* flist.f */
common/mem_pkg.sv
memory/block_memory.sv
cache/icache.sv
cache/dcache.sv
rtl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv
